//--- include/ps2_params.svh
`ifndef PS2_PARAMS_SVH
`define PS2_PARAMS_SVH

// start, eight data bits, parity, stop
`define PS2_FRAME_BITS 11

// key buffer entries, power of two
`define KEY_FIFO_DEPTH 8

// prefix sent by the keyboard on key release
`define PS2_BREAK_CODE 8'hF0

// added to the scan code for the index digits
`define KEY_INDEX_OFFSET 47

`endif

//--- source/ps2_pkg.sv
package ps2_pkg;

    typedef logic [7:0] key_code_t;

    // active low, bit 6 is segment a
    typedef logic [6:0] seg_t;

    localparam seg_t SEG_BLANK = 7'b1111111;

    // A and B cannot be drawn, they show as 0 and 8
    function automatic seg_t seg_hex(input logic [3:0] nibble);
        seg_t seg;
        case (nibble)
            4'h0: seg = 7'b0000001;
            4'h1: seg = 7'b1001111;
            4'h2: seg = 7'b0010010;
            4'h3: seg = 7'b0000110;
            4'h4: seg = 7'b1001100;
            4'h5: seg = 7'b0100100;
            4'h6: seg = 7'b1100000;
            4'h7: seg = 7'b0001111;
            4'h8: seg = 7'b0000000;
            4'h9: seg = 7'b0001100;
            4'hA: seg = 7'b0000001;
            4'hB: seg = 7'b0000000;
            4'hC: seg = 7'b0110001;
            4'hD: seg = 7'b0011100;
            4'hE: seg = 7'b0110000;
            default: seg = 7'b0111000;
        endcase
        return seg;
    endfunction

    // single decimal digit, anything above 9 is dark
    function automatic seg_t seg_dec(input logic [7:0] value);
        seg_t seg;
        if (value > 8'd9) begin
            seg = SEG_BLANK;
        end else begin
            seg = seg_hex(value[3:0]);
        end
        return seg;
    endfunction

endpackage

//--- source/key_fifo_if.sv
`timescale 1ns/100ps

interface key_fifo_if
    import ps2_pkg::*;
#(
    parameter type item_t = key_code_t
) ();

    item_t head;
    logic  ready;
    logic  pop;
    logic  overflow;

    // head is only meaningful while ready is high
    modport fifo (
        output head,
        output ready,
        output overflow,
        input  pop
    );

    modport reader (
        input  head,
        input  ready,
        input  overflow,
        output pop
    );

endinterface

//--- source/ps2_receiver.sv
`timescale 1ns/100ps
`include "ps2_params.svh"

module ps2_receiver
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic       push,
    output key_code_t  code,
    output logic       released,
    output logic [7:0] press_count
);

    localparam int LAST_BIT = `PS2_FRAME_BITS - 1;

    logic [2:0]          clk_sync;
    logic                clk_fall;
    logic [LAST_BIT-1:0] frame_buf;
    logic [3:0]          bit_cnt;
    logic                last_edge;
    logic                frame_ok;
    logic                frame_valid;
    key_code_t           rx_code;
    logic                is_break;
    logic                make_ok;
    logic                break_seen;
    logic                have_last;

    // three flop synchroniser on the keyboard clock
    always_ff @(posedge clk) begin
        if (reset) begin
            clk_sync <= 3'b111;
        end else begin
            clk_sync <= {clk_sync[1:0], ps2_clk};
        end
    end

    assign clk_fall = clk_sync[2] & ~clk_sync[1];

    assign last_edge = clk_fall && (bit_cnt == 4'(LAST_BIT));

    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt <= '0;
        end else if (clk_fall) begin
            if (bit_cnt == 4'(LAST_BIT)) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    // start, data and parity bits land here, the stop bit is read live
    always_ff @(posedge clk) begin
        if (clk_fall && bit_cnt != 4'(LAST_BIT)) begin
            frame_buf[bit_cnt] <= ps2_data;
        end
    end

    assign rx_code = frame_buf[8:1];

    // start low, odd parity over data and parity, stop high
    assign frame_ok = !frame_buf[0] && (^frame_buf[LAST_BIT-1:1]) && ps2_data;

    assign frame_valid = last_edge && frame_ok;
    assign is_break    = rx_code == `PS2_BREAK_CODE;

    // make code that is not the tail of a release sequence
    assign make_ok = frame_valid && !is_break && !break_seen;

    always_ff @(posedge clk) begin
        if (reset) begin
            push        <= 1'b0;
            released    <= 1'b0;
            break_seen  <= 1'b0;
            have_last   <= 1'b0;
            press_count <= '0;
        end else begin
            push <= 1'b0;
            if (frame_valid) begin
                if (is_break) begin
                    released   <= 1'b1;
                    break_seen <= 1'b1;
                end else if (break_seen) begin
                    // released key code, swallowed
                    break_seen <= 1'b0;
                end else begin
                    push      <= 1'b1;
                    released  <= 1'b0;
                    have_last <= 1'b1;
                    // repeats of the held key are not new presses
                    if (!have_last || rx_code != code) begin
                        press_count <= press_count + 8'd1;
                    end
                end
            end
        end
    end

    // holds the last pushed code between frames
    always_ff @(posedge clk) begin
        if (make_ok) begin
            code <= rx_code;
        end
    end

endmodule

//--- source/key_fifo.sv
`timescale 1ns/100ps
`include "ps2_params.svh"

module key_fifo
    import ps2_pkg::*;
#(
    parameter type item_t = key_code_t,
    parameter int  DEPTH  = `KEY_FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  item_t    data,
    key_fifo_if.fifo rd
);

    localparam int AW = $clog2(DEPTH);

    item_t mem [DEPTH];

    // extra msb tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        empty;
    logic        full;
    logic        do_pop;
    logic        do_push;
    logic        overflow_q;

    assign empty = wr_ptr == rd_ptr;
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_pop = rd.pop && !empty;

    // a pop in the same cycle frees the slot the push needs
    assign do_push = push && (!full || do_pop);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            overflow_q <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // sticky until reset
            if (push && !do_push) begin
                overflow_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= data;
        end
    end

    // first word fall through
    assign rd.head     = mem[rd_ptr[AW-1:0]];
    assign rd.ready    = !empty;
    assign rd.overflow = overflow_q;

endmodule

//--- source/key_display.sv
`timescale 1ns/100ps
`include "ps2_params.svh"

module key_display
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       next_key,
    key_fifo_if.reader rd,
    input  logic       released,
    input  logic [7:0] press_count,
    output seg_t       seg0,
    output seg_t       seg1,
    output seg_t       seg2,
    output seg_t       seg3,
    output seg_t       seg4,
    output seg_t       seg5
);

    logic       next_key_q;
    logic       key_rise;
    logic       pop_q;
    key_code_t  head;
    logic [7:0] index;
    logic [7:0] index_ones;
    logic [7:0] index_tens;
    logic [7:0] count_ones;
    logic [7:0] count_tens;

    assign key_rise = next_key && !next_key_q;

    // one pop per press of next_key
    always_ff @(posedge clk) begin
        if (reset) begin
            next_key_q <= 1'b0;
            pop_q      <= 1'b0;
        end else begin
            next_key_q <= next_key;
            pop_q      <= key_rise && rd.ready;
        end
    end

    assign rd.pop = pop_q;

    assign head = rd.head;

    // wraps modulo 256
    assign index = head + 8'(`KEY_INDEX_OFFSET);

    assign index_ones = index % 8'd10;
    assign index_tens = index / 8'd10;
    assign count_ones = press_count % 8'd10;
    assign count_tens = press_count / 8'd10;

    // code and index go dark while a key is released
    assign seg0 = released ? SEG_BLANK : seg_hex(head[3:0]);
    assign seg1 = released ? SEG_BLANK : seg_hex(head[7:4]);
    assign seg2 = released ? SEG_BLANK : seg_dec(index_ones);
    assign seg3 = released ? SEG_BLANK : seg_dec(index_tens);

    // tens above 9 drop out through seg_dec
    assign seg4 = seg_dec(count_ones);
    assign seg5 = seg_dec(count_tens);

endmodule

//--- source/ps2_keyboard_top.sv
`timescale 1ns/100ps

module ps2_keyboard_top
    import ps2_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      ps2_clk,
    input  logic      ps2_data,
    input  logic      next_key,
    output key_code_t key_code,
    output logic      ready,
    output logic      overflow,
    output seg_t      seg0,
    output seg_t      seg1,
    output seg_t      seg2,
    output seg_t      seg3,
    output seg_t      seg4,
    output seg_t      seg5
);

    logic       push;
    key_code_t  code;
    logic       released;
    logic [7:0] press_count;

    key_fifo_if #(.item_t(key_code_t)) key_rd ();

    ps2_receiver ps2_receiver_i (
        .clk         (clk),
        .reset       (reset),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .push        (push),
        .code        (code),
        .released    (released),
        .press_count (press_count)
    );

    key_fifo #(.item_t(key_code_t)) key_fifo_i (
        .clk   (clk),
        .reset (reset),
        .push  (push),
        .data  (code),
        .rd    (key_rd.fifo)
    );

    key_display key_display_i (
        .clk         (clk),
        .reset       (reset),
        .next_key    (next_key),
        .rd          (key_rd.reader),
        .released    (released),
        .press_count (press_count),
        .seg0        (seg0),
        .seg1        (seg1),
        .seg2        (seg2),
        .seg3        (seg3),
        .seg4        (seg4),
        .seg5        (seg5)
    );

    assign key_code = key_rd.head;
    assign ready    = key_rd.ready;
    assign overflow = key_rd.overflow;

endmodule

//--- tb/ps2_keyboard_assert.sv
`timescale 1ns/100ps

module ps2_keyboard_assert
    import ps2_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic ready,
    input logic overflow,
    input logic released,
    input seg_t seg0,
    input seg_t seg1,
    input seg_t seg2,
    input seg_t seg3
);

    // sticky flag, only reset may clear it
    overflow_sticky: assert property (
        @(posedge clk) $past(overflow) && !$past(reset) |-> overflow
    ) else $error("overflow fell without a reset");

    reset_clears_flags: assert property (
        @(posedge clk) reset |=> !ready && !overflow
    ) else $error("ready or overflow high in the cycle after reset");

    // code and index digits dark during a release
    blank_on_release: assert property (
        @(posedge clk) disable iff (reset)
        released |-> (seg0 == SEG_BLANK) && (seg1 == SEG_BLANK)
                  && (seg2 == SEG_BLANK) && (seg3 == SEG_BLANK)
    ) else $error("code digits lit while released is high");

endmodule

bind ps2_keyboard_top ps2_keyboard_assert ps2_keyboard_assert_i (
    .clk      (clk),
    .reset    (reset),
    .ready    (ready),
    .overflow (overflow),
    .released (released),
    .seg0     (seg0),
    .seg1     (seg1),
    .seg2     (seg2),
    .seg3     (seg3)
);

//--- tb/tb_ps2_keyboard.sv
`timescale 1ns/100ps
`include "ps2_params.svh"

module tb_ps2_keyboard
    import ps2_pkg::*;
();

    localparam int HALF_BIT   = 12;
    localparam int WAIT_LIMIT = 400;

    logic      clk;
    logic      reset;
    logic      ps2_clk;
    logic      ps2_data;
    logic      next_key;
    key_code_t key_code;
    logic      ready;
    logic      overflow;
    seg_t      seg0;
    seg_t      seg1;
    seg_t      seg2;
    seg_t      seg3;
    seg_t      seg4;
    seg_t      seg5;

    logic [15:0] lfsr_state = 16'd55541;
    int          checks = 0;
    int          errors = 0;
    int          test_errors = 0;

    // reference model state
    key_code_t  exp_q[$];
    logic       exp_released = 1'b0;
    logic       exp_break = 1'b0;
    logic       exp_have_last = 1'b0;
    logic       exp_overflow = 1'b0;
    key_code_t  exp_last = '0;
    logic [7:0] exp_count = '0;

    ps2_keyboard_top ps2_keyboard_top_i (
        .clk(clk), .reset(reset), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
        .next_key(next_key), .key_code(key_code), .ready(ready), .overflow(overflow),
        .seg0(seg0), .seg1(seg1), .seg2(seg2), .seg3(seg3), .seg4(seg4), .seg5(seg5)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] r;
        logic       fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r = {r[6:0], fb};
        end
        return r;
    endfunction

    function automatic key_code_t random_make_code();
        key_code_t c;
        c = take_bits(8);
        while (c == `PS2_BREAK_CODE || c == 8'hE0) begin
            c = take_bits(8);
        end
        return c;
    endfunction

    task automatic check(input string name, input logic [15:0] expected,
                         input logic [15:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s done, %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    task automatic wait_signal(input logic on_overflow, input logic level, input string what);
        int cycles;
        cycles = 0;
        while (((on_overflow ? overflow : ready) !== level) && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if ((on_overflow ? overflow : ready) !== level) begin
            $display("timeout while waiting for %s", what);
            errors++;
            test_errors++;
        end
    endtask

    task automatic model_frame(input key_code_t c);
        if (c == `PS2_BREAK_CODE) begin
            exp_released = 1'b1;
            exp_break = 1'b1;
        end else if (exp_break) begin
            exp_break = 1'b0;
        end else begin
            if (exp_q.size() < `KEY_FIFO_DEPTH) begin
                exp_q.push_back(c);
            end else begin
                exp_overflow = 1'b1;
            end
            exp_released = 1'b0;
            if (!exp_have_last || c != exp_last) begin
                exp_count = exp_count + 8'd1;
            end
            exp_last = c;
            exp_have_last = 1'b1;
        end
    endtask

    // start, data lsb first, odd parity, stop
    task automatic send_frame(input key_code_t c, input logic bad_parity, input logic bad_stop);
        logic [10:0] bits;
        bits = {~bad_stop, (~^c) ^ bad_parity, c, 1'b0};
        for (int i = 0; i < `PS2_FRAME_BITS; i++) begin
            ps2_data = bits[i];
            repeat (HALF_BIT) @(negedge clk);
            ps2_clk = 1'b0;
            repeat (HALF_BIT) @(negedge clk);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        repeat (HALF_BIT) @(negedge clk);
        if (!bad_parity && !bad_stop) begin
            model_frame(c);
        end
    endtask

    task automatic press_next_key();
        int hold;
        hold = 1 + take_bits(2);
        next_key = 1'b1;
        repeat (hold) @(negedge clk);
        next_key = 1'b0;
        repeat (2) @(negedge clk);
        if (exp_q.size() > 0) begin
            void'(exp_q.pop_front());
        end
    endtask

    task automatic check_display(input string name);
        key_code_t  head;
        logic [7:0] index;
        head = exp_q.size() > 0 ? exp_q[0] : 8'h00;
        index = head + 8'd47;
        if (exp_released) begin
            check({name, " seg0"}, SEG_BLANK, seg0);
            check({name, " seg1"}, SEG_BLANK, seg1);
            check({name, " seg2"}, SEG_BLANK, seg2);
            check({name, " seg3"}, SEG_BLANK, seg3);
        end else if (exp_q.size() > 0) begin
            check({name, " seg0"}, seg_hex(head[3:0]), seg0);
            check({name, " seg1"}, seg_hex(head[7:4]), seg1);
            check({name, " seg2"}, seg_dec(index % 10), seg2);
            check({name, " seg3"}, seg_dec(index / 10), seg3);
        end
        check({name, " seg4"}, seg_dec(exp_count % 10), seg4);
        check({name, " seg5"}, seg_dec(exp_count / 10), seg5);
    endtask

    // one key through the whole path, then popped
    task automatic make_and_pop(input string name);
        send_frame(random_make_code(), 1'b0, 1'b0);
        wait_signal(1'b0, 1'b1, "ready after a make code");
        check({name, " key_code"}, exp_q[0], key_code);
        check_display(name);
        press_next_key();
        wait_signal(1'b0, 1'b0, "ready to fall after a pop");
    endtask

    initial begin
        key_code_t c;
        reset = 1'b1;
        ps2_clk = 1'b1;
        ps2_data = 1'b1;
        next_key = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        check("reset ready", 1'b0, ready);
        check("reset overflow", 1'b0, overflow);
        check_display("reset");
        end_test("reset");

        for (int i = 0; i < 12; i++) begin
            make_and_pop("make");
        end
        end_test("make codes");

        for (int i = 0; i < 6; i++) begin
            c = random_make_code();
            if (take_bits(1)) begin
                send_frame(c, 1'b1, 1'b0);
            end else begin
                send_frame(c, 1'b0, 1'b1);
            end
            check("bad frame ready", 1'b0, ready);
        end
        make_and_pop("after bad frames");
        end_test("bad frames");

        for (int i = 0; i < 6; i++) begin
            make_and_pop("before release");
            if (i == 0 || take_bits(1)) begin
                send_frame(`PS2_BREAK_CODE, 1'b0, 1'b0);
                send_frame(exp_last, 1'b0, 1'b0);
                check("release ready", 1'b0, ready);
                check_display("release");
            end
        end
        make_and_pop("after release");
        end_test("release");

        // overflow must stay low until the buffer is full
        for (int i = 0; i < `KEY_FIFO_DEPTH; i++) begin
            send_frame(random_make_code(), 1'b0, 1'b0);
            check("filling overflow", exp_overflow, overflow);
        end
        send_frame(random_make_code(), 1'b0, 1'b0);
        wait_signal(1'b1, 1'b1, "overflow on the ninth push");
        for (int i = 0; i < `KEY_FIFO_DEPTH; i++) begin
            wait_signal(1'b0, 1'b1, "ready while draining");
            check("drain key_code", exp_q[0], key_code);
            press_next_key();
        end
        wait_signal(1'b0, 1'b0, "ready to fall after draining");
        check("drained overflow", exp_overflow, overflow);
        end_test("overflow");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+include
source/ps2_pkg.sv
source/key_fifo_if.sv
source/ps2_receiver.sv
source/key_fifo.sv
source/key_display.sv
source/ps2_keyboard_top.sv
tb/ps2_keyboard_assert.sv
tb/tb_ps2_keyboard.sv
